// File: verilog/tdc_stream_pkg.sv
`default_nettype none

package tdc_stream_pkg;

    // tdc and mirror channel count
    localparam int num_channels = 6;

    // one raw tdc measurement
    typedef logic [31:0] tdc_value_t;

    // uart bytes per record, lsb first on the line
    localparam int bytes_per_record = 6;

    // record layout: payload in [47:16], channel id 1..6 in [15:0]
    typedef logic [8*bytes_per_record-1:0] record_t;

    // marker payload words, repeated twice in the upper 32 bits
    localparam logic [15:0] line_tag  = 16'h000D;
    localparam logic [15:0] frame_tag = 16'h000E;

    // record queue between arbiter and serial link
    localparam int fifo_depth  = 16;
    localparam int fifo_addr_w = 4;

    // uart bit period in clocks
    // kept short so a full record drains quickly in simulation
    localparam int clk_per_bit = 8;

endpackage

`default_nettype wire

// File: verilog/readout_control.sv
`timescale 1ns/10ps
`default_nettype none

module readout_control
    import tdc_stream_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  tdc_value_t [num_channels-1:0] tdc_data,
    input  logic [num_channels-1:0]       tdc_wr_en,
    input  logic [num_channels-1:0]       new_line,
    input  logic [num_channels-1:0]       new_frame,
    input  logic                          fifo_empty,
    input  logic                          busy,
    output logic [num_channels-1:0]       wr_done,
    output logic [num_channels-1:0]       line_done,
    output logic [num_channels-1:0]       frame_done,
    output logic                          fifo_wr,
    output record_t                       fifo_din,
    output logic                          fifo_rd,
    output logic                          load
);

    // one-hot grant before the output registers
    logic [num_channels-1:0] wr_next;
    logic [num_channels-1:0] line_next;
    logic [num_channels-1:0] frame_next;
    logic                    found;
    record_t                 din_next;

    // fixed priority encoder over 18 request bits
    always_comb begin
        found      = 1'b0;
        wr_next    = '0;
        line_next  = '0;
        frame_next = '0;
        din_next   = '0;
        // tdc writes win over any marker, channel 1 first
        for (int i = 0; i < num_channels; i++) begin
            if (!found && tdc_wr_en[i]) begin
                found      = 1'b1;
                wr_next[i] = 1'b1;
                din_next   = {tdc_data[i], 16'(i + 1)};
            end
        end
        // markers per channel, line ahead of frame
        for (int i = 0; i < num_channels; i++) begin
            if (!found && new_line[i]) begin
                found        = 1'b1;
                line_next[i] = 1'b1;
                din_next     = {line_tag, line_tag, 16'(i + 1)};
            end
            if (!found && new_frame[i]) begin
                found         = 1'b1;
                frame_next[i] = 1'b1;
                din_next      = {frame_tag, frame_tag, 16'(i + 1)};
            end
        end
    end

    // done pulses and fifo write, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_done    <= '0;
            line_done  <= '0;
            frame_done <= '0;
            fifo_wr    <= 1'b0;
        end else begin
            wr_done    <= wr_next;
            line_done  <= line_next;
            frame_done <= frame_next;
            // write even when full, fifo drops it
            fifo_wr    <= found;
        end
    end

    // record data follows fifo_wr
    always_ff @(posedge clk) begin
        fifo_din <= din_next;
    end

    // pop when serializer idle
    // fifo_rd and load block a second pop until busy comes up
    always_ff @(posedge clk) begin
        if (rst) begin
            fifo_rd <= 1'b0;
            load    <= 1'b0;
        end else begin
            fifo_rd <= !fifo_empty && !busy && !fifo_rd && !load;
            // fifo_dout valid in the cycle after the pop
            load    <= fifo_rd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/record_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module record_fifo
    import tdc_stream_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    wr,
    input  record_t din,
    input  logic    rd,
    output record_t dout,
    output logic    empty,
    output logic    full
);

    record_t                mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    // one extra bit so a full buffer is distinct from empty
    logic [fifo_addr_w:0]   count;
    logic                   do_wr;
    logic                   do_rd;

    assign empty = (count == '0);
    assign full  = (count == (fifo_addr_w + 1)'(fifo_depth));

    // writes while full and reads while empty are ignored
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        // dout holds the popped record the cycle after rd
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/word_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module word_serializer
    import tdc_stream_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  record_t    record,
    input  logic       byte_busy,
    output logic       busy,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    typedef enum logic [1:0] {
        s_idle,
        s_send,
        s_wait
    } state_t;

    state_t                              state;
    record_t                             shreg;
    logic [$clog2(bytes_per_record)-1:0] byte_cnt;

    // high from the cycle after load until the last stop bit ends
    assign busy = (state != s_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= s_idle;
            byte_cnt   <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                s_idle: begin
                    if (load) begin
                        byte_cnt <= '0;
                        state    <= s_send;
                    end
                end
                s_send: begin
                    if (!byte_busy) begin
                        byte_valid <= 1'b1;
                        state      <= s_wait;
                    end
                end
                s_wait: begin
                    // byte_busy rises only after the byte_valid cycle
                    if (!byte_valid && !byte_busy) begin
                        if (int'(byte_cnt) == bytes_per_record - 1) begin
                            state <= s_idle;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= s_send;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // record shifter, low byte goes out first
    always_ff @(posedge clk) begin
        if (state == s_idle && load) begin
            shreg <= record;
        end else if (state == s_send && !byte_busy) begin
            byte_data <= shreg[7:0];
            shreg     <= shreg >> 8;
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx
    import tdc_stream_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       tx,
    output logic       byte_busy
);

    // 8n1 frame: start bit in [0], data lsb first, stop bit in [9]
    logic [9:0]                         frame_q;
    logic [$clog2(clk_per_bit)-1:0]     bit_timer;
    logic [3:0]                         bit_idx;

    // line follows the low end of the shifter
    assign tx = frame_q[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            // all ones keeps the line idle high
            frame_q   <= '1;
            bit_timer <= '0;
            bit_idx   <= '0;
            byte_busy <= 1'b0;
        end else if (!byte_busy) begin
            if (byte_valid) begin
                // start bit goes out on this edge
                frame_q   <= {1'b1, byte_data, 1'b0};
                bit_timer <= '0;
                bit_idx   <= '0;
                byte_busy <= 1'b1;
            end
        end else if (int'(bit_timer) == clk_per_bit - 1) begin
            // end of a bit period, move to the next bit
            bit_timer <= '0;
            frame_q   <= {1'b1, frame_q[9:1]};
            if (bit_idx == 4'd9) begin
                // stop bit done
                byte_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            bit_timer <= bit_timer + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/tdc_stream_top.sv
`timescale 1ns/10ps
`default_nettype none

module tdc_stream_top
    import tdc_stream_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  tdc_value_t [num_channels-1:0] tdc_data,
    input  logic [num_channels-1:0]       tdc_wr_en,
    input  logic [num_channels-1:0]       new_line,
    input  logic [num_channels-1:0]       new_frame,
    output logic [num_channels-1:0]       wr_done,
    output logic [num_channels-1:0]       line_done,
    output logic [num_channels-1:0]       frame_done,
    output logic                          tx
);

    // arbiter to fifo
    logic    fifo_wr;
    record_t fifo_din;
    logic    fifo_rd;
    logic    fifo_empty;
    record_t fifo_dout;

    // fifo to serial link
    logic       load;
    logic       busy;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       byte_busy;

    readout_control readout_control_i (
        .clk        (clk),
        .rst        (rst),
        .tdc_data   (tdc_data),
        .tdc_wr_en  (tdc_wr_en),
        .new_line   (new_line),
        .new_frame  (new_frame),
        .fifo_empty (fifo_empty),
        .busy       (busy),
        .wr_done    (wr_done),
        .line_done  (line_done),
        .frame_done (frame_done),
        .fifo_wr    (fifo_wr),
        .fifo_din   (fifo_din),
        .fifo_rd    (fifo_rd),
        .load       (load)
    );

    // full not needed, writes to a full fifo are dropped inside
    record_fifo record_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (fifo_wr),
        .din   (fifo_din),
        .rd    (fifo_rd),
        .dout  (fifo_dout),
        .empty (fifo_empty),
        .full  ()
    );

    word_serializer word_serializer_i (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .record     (fifo_dout),
        .byte_busy  (byte_busy),
        .busy       (busy),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    uart_tx uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .tx         (tx),
        .byte_busy  (byte_busy)
    );

endmodule

`default_nettype wire

// File: sim/tb_tdc_stream.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tdc_stream
    import tdc_stream_pkg::*;
;

    localparam int kind_tdc   = 0;
    localparam int kind_line  = 1;
    localparam int kind_frame = 2;

    logic                          clk = 1'b0;
    logic                          rst;
    tdc_value_t [num_channels-1:0] tdc_data;
    logic [num_channels-1:0]       tdc_wr_en;
    logic [num_channels-1:0]       new_line;
    logic [num_channels-1:0]       new_frame;
    logic [num_channels-1:0]       wr_done;
    logic [num_channels-1:0]       line_done;
    logic [num_channels-1:0]       frame_done;
    logic                          tx;

    int      seed = 32'h158f;
    int      mismatches = 0;
    int      failures = 0;
    record_t exp_q[$];
    record_t rx_q[$];

    tdc_stream_top tdc_stream_top_i (
        .clk        (clk),
        .rst        (rst),
        .tdc_data   (tdc_data),
        .tdc_wr_en  (tdc_wr_en),
        .new_line   (new_line),
        .new_frame  (new_frame),
        .wr_done    (wr_done),
        .line_done  (line_done),
        .frame_done (frame_done),
        .tx         (tx)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // payload on top and channel id in the low half word
    function automatic record_t expected_record(input int ch, input int kind,
                                                input tdc_value_t value);
        case (kind)
            kind_line:  return {16'h000D, 16'h000D, 16'(ch)};
            kind_frame: return {16'h000E, 16'h000E, 16'(ch)};
            default:    return {value, 16'(ch)};
        endcase
    endfunction

    // done layout {frame_done, line_done, wr_done}
    function automatic logic [3*num_channels-1:0] done_vector(input int kind, input int ch);
        logic [3*num_channels-1:0] v;
        v = '0;
        v[kind * num_channels + ch - 1] = 1'b1;
        return v;
    endfunction

    // all tdc writes first and then line before frame per channel
    function automatic void pick_source(input logic [5:0] wm, input logic [5:0] lm,
                                        input logic [5:0] fm, output int kind, output int ch);
        logic [2*num_channels-1:0] order;
        kind  = -1;
        ch    = 0;
        order = '0;
        for (int c = num_channels - 1; c >= 0; c--) begin
            order = {order[2*num_channels-3:0], fm[c], lm[c]};
        end
        for (int c = 0; c < num_channels && kind < 0; c++) begin
            if (wm[c]) begin
                kind = kind_tdc;
                ch   = c + 1;
            end
        end
        for (int k = 0; k < 2 * num_channels && kind < 0; k++) begin
            if (order[k]) begin
                kind = (k % 2 == 0) ? kind_line : kind_frame;
                ch   = k / 2 + 1;
            end
        end
    endfunction

    // one-cycle request pulse
    task automatic send_requests(input logic [5:0] wm, input logic [5:0] lm,
                                 input logic [5:0] fm, input tdc_value_t [5:0] data);
        @(posedge clk);
        tdc_data  <= data;
        tdc_wr_en <= wm;
        new_line  <= lm;
        new_frame <= fm;
        @(posedge clk);
        tdc_wr_en <= '0;
        new_line  <= '0;
        new_frame <= '0;
    endtask

    task automatic wait_done(input logic [3*num_channels-1:0] exp_vec);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 8) begin
            @(negedge clk);
            seen = ({frame_done, line_done, wr_done} != '0);
            n++;
        end
        if (!seen) begin
            $display("timeout at %0t ns: no done pulse after a request", $time);
            failures++;
        end else begin
            check_value("done", 64'({frame_done, line_done, wr_done}), 64'(exp_vec));
            // pulse must be one cycle long
            @(negedge clk);
            check_value("done_after_pulse", 64'({frame_done, line_done, wr_done}), 64'(0));
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t ns: %0d expected records never arrived",
                     $time, exp_q.size());
            failures++;
        end
    endtask

    // uart receive model sampling mid bit on falling clock edges
    always begin : uart_rx
        record_t    rec;
        logic [7:0] rx_byte;
        for (int b = 0; b < bytes_per_record; b++) begin
            @(negedge clk);
            while (tx !== 1'b0) @(negedge clk);
            repeat (clk_per_bit / 2 - 1) @(negedge clk);
            if (tx !== 1'b0) begin
                $display("start bit too short at %0t ns", $time);
                failures++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (clk_per_bit) @(negedge clk);
                rx_byte[i] = tx;
            end
            repeat (clk_per_bit) @(negedge clk);
            if (tx !== 1'b1) begin
                $display("stop bit missing at %0t ns", $time);
                failures++;
            end
            rec[b*8 +: 8] = rx_byte;
        end
        rx_q.push_back(rec);
    end

    // compare received records against issue order
    always @(posedge clk) begin : compare
        record_t got;
        if (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("unexpected record %h received at %0t ns", got, $time);
                failures++;
            end else begin
                check_value("record", 64'(got), 64'(exp_q.pop_front()));
            end
        end
    end

    initial begin
        tdc_value_t [num_channels-1:0] data;
        logic [5:0]                    wm;
        logic [5:0]                    lm;
        logic [5:0]                    fm;
        int                            kind;
        int                            ch;
        rst       = 1'b1;
        tdc_data  = '0;
        tdc_wr_en = '0;
        new_line  = '0;
        new_frame = '0;
        data      = '0;

        // line idle and no done pulses during and after reset
        repeat (7) begin
            @(negedge clk);
            check_value("tx", 64'(tx), 64'(1));
            check_value("done", 64'({frame_done, line_done, wr_done}), 64'(0));
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("tx", 64'(tx), 64'(1));
            check_value("done", 64'({frame_done, line_done, wr_done}), 64'(0));
        end

        // single tdc events
        for (int t = 0; t < 3; t++) begin
            ch = 1 + int'($unsigned($random(seed)) % num_channels);
            data = '0;
            data[ch-1] = $random(seed);
            exp_q.push_back(expected_record(ch, kind_tdc, data[ch-1]));
            send_requests(6'b1 << (ch - 1), '0, '0, data);
            wait_done(done_vector(kind_tdc, ch));
            wait_drain(2000);
        end

        // only the winner of simultaneous requests comes through
        for (int t = 0; t < 8; t++) begin
            for (int c = 0; c < num_channels; c++) begin
                data[c] = $random(seed);
            end
            wm = 6'($random(seed) & $random(seed));
            lm = 6'($random(seed) & $random(seed));
            fm = 6'($random(seed) & $random(seed));
            // odd trials let markers compete alone
            if (t % 2 == 1) begin
                wm = '0;
            end
            if ((wm | lm | fm) == '0) begin
                fm[5] = 1'b1;
            end
            pick_source(wm, lm, fm, kind, ch);
            exp_q.push_back(expected_record(ch, kind, data[ch-1]));
            send_requests(wm, lm, fm, data);
            wait_done(done_vector(kind, ch));
            wait_drain(2000);
        end

        // line and frame markers on every channel
        for (int c = 1; c <= num_channels; c++) begin
            exp_q.push_back(expected_record(c, kind_line, '0));
            send_requests('0, 6'b1 << (c - 1), '0, data);
            wait_done(done_vector(kind_line, c));
            exp_q.push_back(expected_record(c, kind_frame, '0));
            send_requests('0, '0, 6'b1 << (c - 1), data);
            wait_done(done_vector(kind_frame, c));
        end
        wait_drain(12000);

        // back to back burst that drains slowly over the serial link
        for (int i = 0; i < fifo_depth - 4; i++) begin
            kind = int'($unsigned($random(seed)) % 3);
            ch   = 1 + int'($unsigned($random(seed)) % num_channels);
            data = '0;
            data[ch-1] = $random(seed);
            @(posedge clk);
            tdc_data  <= data;
            tdc_wr_en <= (kind == kind_tdc) ? 6'b1 << (ch - 1) : 6'b0;
            new_line  <= (kind == kind_line) ? 6'b1 << (ch - 1) : 6'b0;
            new_frame <= (kind == kind_frame) ? 6'b1 << (ch - 1) : 6'b0;
            exp_q.push_back(expected_record(ch, kind, data[ch-1]));
        end
        @(posedge clk);
        tdc_wr_en <= '0;
        new_line  <= '0;
        new_frame <= '0;
        wait_drain(12000);

        // quiet window so a stray record would still show up
        repeat (bytes_per_record * 10 * clk_per_bit + 100) @(posedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
verilog/tdc_stream_pkg.sv
verilog/readout_control.sv
verilog/record_fifo.sv
verilog/word_serializer.sv
verilog/uart_tx.sv
verilog/tdc_stream_top.sv
sim/tb_tdc_stream.sv

// File: Makefile
# Verilator build and run for the TDC readout stream testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_tdc_stream \
		-f files.f -o sim_tdc_stream

run: compile
	./obj_dir/sim_tdc_stream | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
